//--- project.f
+incdir+design
design/ps2_pkg.sv
design/ps2_xtcodes.sv
design/ps2_link_rx.sv
design/ps2_scancode_unit.sv
design/ps2_code_buffer.sv
design/ps2_kbd_port.sv
tests/tb_clock.sv
tests/ps2_device_model.sv
tests/tb_ps2_kbd.sv

//--- tests/tb_ps2_kbd.sv
`timescale 1ns/1ps
`include "ps2_cfg.svh"

module tb_ps2_kbd;

  // 40 frames of 11 bits at the watchdog bit time, plus slack
  localparam int timeout_cycles   = 40 * 11 * `PS2_TIMER_60USEC + 100000;
  localparam int valid_wait_limit = 200;   // Cycles from frame end to code_valid

  logic                clk;
  logic                reset;
  logic                ps2_clk;
  logic                ps2_data;
  logic                rd;
  ps2_pkg::scan_byte_t code;
  logic                code_valid;
  logic                overrun;

  int          cycle_count;
  logic [31:0] rng_state;

  tb_clock u_clock (
    .clk   (clk),
    .reset (reset)
  );

  ps2_device_model u_keyboard (
    .clk      (clk),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data)
  );

  ps2_kbd_port u_dut (
    .clk        (clk),
    .reset      (reset),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .rd         (rd),
    .code       (code),
    .code_valid (code_valid),
    .overrun    (overrun)
  );

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic abort_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(input string test_name, input logic [7:0] expected,
                             input logic [7:0] actual);
    if (expected !== actual)
    begin
      $display("[ERROR] %s expected %02h actual %02h", test_name, expected, actual);
      abort_run();
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Bytes of 80h and up, F0 excluded since it is the break prefix
  task automatic random_high_byte(output logic [7:0] b);
    do
    begin
      rng_state = xorshift32(rng_state);
      b = {1'b1, rng_state[6:0]};
    end
    while (b == 8'hF0);
  endtask

  task automatic send_byte(input logic [7:0] b);
    u_keyboard.send_frame(b, 1'b0, 11);
  endtask

  task automatic wait_code_valid(input string test_name);
    int n;
    n = 0;
    while (code_valid !== 1'b1)
    begin
      if (n == valid_wait_limit)
      begin
        $display("No code showed up in test %s although one was expected", test_name);
        abort_run();
      end
      @(negedge clk);
      n++;
    end
  endtask

  // Check the oldest code, then pop it with a one-cycle rd
  task automatic read_code(input string test_name, input logic [7:0] expected);
    wait_code_valid(test_name);
    check_value(test_name, expected, code);
    rd = 1'b1;
    @(negedge clk);
    rd = 1'b0;
    @(negedge clk);
  endtask

  task automatic expect_empty(input string test_name);
    check_value(test_name, 8'h00, {7'd0, code_valid});
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic test_make_codes();
    send_byte(8'h1C);
    read_code("make_codes", 8'h1E);    // A
    expect_empty("make_codes");
    send_byte(8'h32);
    read_code("make_codes", 8'h30);    // B
    expect_empty("make_codes");
    send_byte(8'h76);
    read_code("make_codes", 8'h01);    // Esc
    expect_empty("make_codes");
  endtask

  task automatic test_break_prefix();
    send_byte(8'hF0);
    expect_empty("break_prefix");      // Prefix alone gives nothing
    send_byte(8'h5A);
    read_code("break_prefix", 8'h9C);  // Enter released
    expect_empty("break_prefix");
    send_byte(8'h5A);
    read_code("break_prefix", 8'h1C);  // Flag gone, plain make
  endtask

  task automatic test_high_bytes();
    logic [7:0] b;
    int         k;
    for (k = 0; k < 4; k++)
    begin
      random_high_byte(b);
      send_byte(b);
      read_code("high_bytes", b);      // Raw pass through
      expect_empty("high_bytes");
    end
    send_byte(8'h00);
    expect_empty("high_bytes");
    send_byte(8'hF0);
    expect_empty("high_bytes");
    random_high_byte(b);
    send_byte(b);
    read_code("high_bytes", b);        // Bit 7 already set, unchanged
    send_byte(8'h1C);
    read_code("high_bytes", 8'h1E);
  endtask

  task automatic test_shift_trap();
    send_byte(`PS2_LEFT_SHIFT);
    expect_empty("shift_trap");
    send_byte(`PS2_RIGHT_SHIFT);
    expect_empty("shift_trap");
    send_byte(8'h29);
    read_code("shift_trap", 8'h39);    // Space
  endtask

  task automatic test_bad_frames();
    u_keyboard.send_frame(8'h21, 1'b1, 11);   // Parity flipped
    expect_empty("bad_frames");
    u_keyboard.send_frame(8'h33, 1'b0, 5);    // Cut off mid-frame
    repeat (2 * `PS2_TIMER_60USEC) @(negedge clk);   // Silence past the watchdog
    expect_empty("bad_frames");
    send_byte(8'h21);
    read_code("bad_frames", 8'h2E);    // Link realigned
  endtask

  task automatic test_overrun();
    send_byte(8'h1C);
    send_byte(8'h32);
    send_byte(8'h76);
    send_byte(8'h5A);
    send_byte(8'h29);                  // Fifth code finds the buffer full
    check_value("overrun", 8'h01, {7'd0, overrun});
    read_code("overrun", 8'h1E);
    check_value("overrun", 8'h00, {7'd0, overrun});   // Cleared by the read
    read_code("overrun", 8'h30);
    read_code("overrun", 8'h01);
    read_code("overrun", 8'h1C);
    expect_empty("overrun");           // Space was dropped
  endtask

  // ----------------------------------------
  // Timeout
  // ----------------------------------------
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= timeout_cycles)
    begin
      $display("Run did not finish within %0d clock cycles", timeout_cycles);
      abort_run();
    end
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial
  begin
    rd          = 1'b0;
    cycle_count = 0;
    rng_state   = 32'd95;
    wait (reset === 1'b0);
    @(negedge clk);
    expect_empty("after_reset");
    check_value("after_reset", 8'h00, {7'd0, overrun});
    test_make_codes();
    test_break_prefix();
    test_high_bytes();
    test_shift_trap();
    test_bad_frames();
    test_overrun();
    $display("Everything OK");
    $finish;
  end

endmodule

//--- tests/ps2_device_model.sv
`timescale 1ns/1ps
`include "ps2_cfg.svh"

module ps2_device_model (
  input  logic clk,                    // System clock, used as time base only
  output logic ps2_clk,
  output logic ps2_data
);

  // Half a PS/2 bit, kept well inside the watchdog window
  localparam int half_bit = (`PS2_TIMER_60USEC / 2) - 100;

  initial
  begin
    ps2_clk  = 1'b1;                   // Bus idle
    ps2_data = 1'b1;
  end

  // ----------------------------------------
  // One frame, LSB first
  // ----------------------------------------
  // bit_limit below 11 cuts the frame off after that many bits
  task automatic send_frame(input logic [7:0] data, input bit bad_parity,
                            input int bit_limit);
    logic [10:0] frame;
    logic        parity;
    int          i;
    parity = ~^data;                   // Odd parity over data and parity bit
    if (bad_parity)
      parity = ~parity;
    frame = {1'b1, parity, data, 1'b0};   // Stop, parity, data, start
    for (i = 0; i < bit_limit; i++)
    begin
      @(negedge clk);
      ps2_data = frame[i];             // Data settles while clock is high
      repeat (half_bit) @(negedge clk);
      ps2_clk = 1'b0;                  // Host samples on this fall
      repeat (half_bit) @(negedge clk);
      ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
    repeat (half_bit) @(negedge clk);  // Idle gap after the frame
  endtask

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic reset
);

  localparam int reset_cycles = 10;

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;            // 20 ns period, 50 MHz
  end

  initial
  begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;                      // Released away from the sampling edge
  end

endmodule

//--- design/ps2_kbd_port.sv
`timescale 1ns/1ps
`include "ps2_cfg.svh"

module ps2_kbd_port (
  input  logic                clk,
  input  logic                reset,
  input  logic                ps2_clk,      // Keyboard clock, asynchronous
  input  logic                ps2_data,     // Keyboard data, asynchronous
  input  logic                rd,           // Host read pulse
  output ps2_pkg::scan_byte_t code,
  output logic                code_valid,
  output logic                overrun
);

  // ----------------------------------------
  // Internal strobes
  // ----------------------------------------
  ps2_pkg::scan_byte_t frame_byte;
  logic                frame_done;
  ps2_pkg::scan_byte_t code_byte;
  logic                code_strobe;

  // Wire side, frames in
  ps2_link_rx u_link (
    .clk        (clk),
    .reset      (reset),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .frame_byte (frame_byte),
    .frame_done (frame_done)
  );

  // Set 2 bytes to set 1 codes
  ps2_scancode_unit #(
    .trap_shift_keys (`PS2_TRAP_SHIFT)
  ) u_scancode (
    .clk         (clk),
    .reset       (reset),
    .frame_byte  (frame_byte),
    .frame_done  (frame_done),
    .code_byte   (code_byte),
    .code_strobe (code_strobe)
  );

  // Host side queue
  ps2_code_buffer u_buffer (
    .clk         (clk),
    .reset       (reset),
    .code_byte   (code_byte),
    .code_strobe (code_strobe),
    .rd          (rd),
    .code        (code),
    .code_valid  (code_valid),
    .overrun     (overrun)
  );

endmodule

//--- design/ps2_code_buffer.sv
`timescale 1ns/1ps
`include "ps2_cfg.svh"

module ps2_code_buffer (
  input  logic                clk,
  input  logic                reset,
  input  ps2_pkg::scan_byte_t code_byte,
  input  logic                code_strobe,
  input  logic                rd,           // Host pop pulse
  output ps2_pkg::scan_byte_t code,         // Oldest entry
  output logic                code_valid,
  output logic                overrun       // A code was dropped
);

  localparam int depth    = `PS2_BUF_DEPTH;
  localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_bits = $clog2(depth + 1);
  localparam logic [ptr_bits-1:0] last_slot = ptr_bits'(depth - 1);
  localparam logic [cnt_bits-1:0] full_count = cnt_bits'(depth);

  ps2_pkg::scan_byte_t mem [depth];
  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] count;
  logic                full;
  logic                do_pop;
  logic                do_push;

  assign full       = (count == full_count);
  assign code_valid = (count != '0);
  assign code       = mem[rd_ptr];
  assign do_pop     = rd && code_valid;                  // Pop on empty is ignored
  assign do_push    = code_strobe && (!full || do_pop);  // Same-cycle pop frees a slot

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= code_byte;
  end

  // ----------------------------------------
  // Pointers, count and overrun
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      overrun <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
      if (code_strobe && !do_push)
        overrun <= 1'b1;                 // New byte lost
      else if (rd)
        overrun <= 1'b0;
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (reset)
    count <= full_count);

endmodule

//--- design/ps2_scancode_unit.sv
`timescale 1ns/1ps
`include "ps2_cfg.svh"

module ps2_scancode_unit #(
  parameter bit trap_shift_keys = `PS2_TRAP_SHIFT
) (
  input  logic                clk,
  input  logic                reset,
  input  ps2_pkg::scan_byte_t frame_byte,
  input  logic                frame_done,
  output ps2_pkg::scan_byte_t code_byte,    // Set 1 code or raw high byte
  output logic                code_strobe   // One cycle after frame_done
);

  ps2_pkg::at_code_t at_code;
  ps2_pkg::xt_code_t xt_code;
  logic              released;              // F0 seen, next key is a break
  logic              is_release;
  logic              is_shift;
  logic              emit;

  assign at_code = frame_byte[6:0];

  ps2_xtcodes u_xtcodes (
    .at_code (at_code),
    .xt_code (xt_code)
  );

  // ----------------------------------------
  // Code classification
  // ----------------------------------------
  assign is_release = (frame_byte == `PS2_RELEASE_CODE);
  assign is_shift   = (frame_byte == `PS2_LEFT_SHIFT) || (frame_byte == `PS2_RIGHT_SHIFT);

  // Zero, F0 and trapped shifts never reach the buffer
  assign emit = frame_done && (frame_byte != 8'h00) && !is_release
             && !(trap_shift_keys && is_shift);

  // Prefix flag, any following key consumes it, trapped or not
  always_ff @(posedge clk)
  begin
    if (reset)
      released <= 1'b0;
    else if (frame_done)
      released <= is_release;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      code_strobe <= 1'b0;
    else
      code_strobe <= emit;
  end

  // High bytes (E0, FA, FE...) go out untranslated
  always_ff @(posedge clk)
  begin
    if (emit)
      code_byte <= frame_byte[7] ? frame_byte : {released, xt_code};
  end

  // Every strobe hands the buffer a fully known byte
  a_strobe_byte_known: assert property (@(posedge clk) disable iff (reset)
    code_strobe |-> !$isunknown(code_byte));

endmodule

//--- design/ps2_link_rx.sv
`timescale 1ns/1ps
`include "ps2_cfg.svh"

module ps2_link_rx (
  input  logic                clk,
  input  logic                reset,
  input  logic                ps2_clk,     // Straight from the pad
  input  logic                ps2_data,    // Straight from the pad
  output ps2_pkg::scan_byte_t frame_byte,  // Held until the next frame_done
  output logic                frame_done   // One cycle per good frame
);

  localparam int frame_bits = 11;                      // Start, 8 data, parity, stop
  localparam logic [3:0] last_index = 4'(frame_bits - 1);
  localparam logic [`PS2_TIMER_BITS-1:0] timer_limit = `PS2_TIMER_60USEC;

  // Synchronizer stages
  logic ps2_clk_meta;
  logic ps2_clk_s;
  logic ps2_data_meta;
  logic ps2_data_s;

  ps2_pkg::link_state_t state;
  ps2_pkg::link_state_t next_state;

  logic [`PS2_TIMER_BITS-1:0] timer_count;
  logic                       timer_run;
  logic                       timer_done;

  logic [3:0]            bit_count;
  logic [frame_bits-1:0] shift_q;
  logic [frame_bits-1:0] frame_next;   // Shift register after this sample
  logic                  sample;       // Falling edge marker active
  logic                  last_bit;
  logic                  frame_ok;

  // ----------------------------------------
  // Input synchronizers
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ps2_clk_meta  <= 1'b1;           // Lines idle high
      ps2_clk_s     <= 1'b1;
      ps2_data_meta <= 1'b1;
      ps2_data_s    <= 1'b1;
    end
    else
    begin
      ps2_clk_meta  <= ps2_clk;
      ps2_clk_s     <= ps2_clk_meta;
      ps2_data_meta <= ps2_data;
      ps2_data_s    <= ps2_data_meta;
    end
  end

  // ----------------------------------------
  // Edge marker FSM
  // ----------------------------------------
  always_comb
  begin
    case (state)
      ps2_pkg::clk_high:  next_state = ps2_clk_s ? ps2_pkg::clk_high : ps2_pkg::fall_mark;
      ps2_pkg::fall_mark: next_state = ps2_pkg::clk_low;
      ps2_pkg::clk_low:   next_state = ps2_clk_s ? ps2_pkg::rise_mark : ps2_pkg::clk_low;
      ps2_pkg::rise_mark: next_state = ps2_pkg::clk_high;
      default:            next_state = ps2_pkg::clk_high;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= ps2_pkg::clk_high;
    else
      state <= next_state;
  end

  assign sample = (state == ps2_pkg::fall_mark);

  // ----------------------------------------
  // 60 us watchdog
  // ----------------------------------------
  // Runs in both level states, restarts on every edge marker
  assign timer_run  = (state == ps2_pkg::clk_high) || (state == ps2_pkg::clk_low);
  assign timer_done = (timer_count == timer_limit);

  always_ff @(posedge clk)
  begin
    if (reset || !timer_run)
      timer_count <= '0;
    else if (!timer_done)
      timer_count <= timer_count + 1'b1;   // Saturates at the limit
  end

  // ----------------------------------------
  // Frame assembly and checks
  // ----------------------------------------
  assign frame_next = {ps2_data_s, shift_q[frame_bits-1:1]};   // LSB arrives first
  assign last_bit   = (bit_count == last_index);

  // Start low, stop high, odd parity over data and parity bit
  assign frame_ok = !frame_next[0] && frame_next[10] && (^frame_next[9:1]);

  always_ff @(posedge clk)
  begin
    if (sample)
      shift_q <= frame_next;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      bit_count <= '0;
    else if (sample)
      bit_count <= last_bit ? 4'd0 : bit_count + 4'd1;
    else if (timer_done && (state == ps2_pkg::clk_high))
      bit_count <= '0;                  // Keyboard went quiet mid-frame
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      frame_done <= 1'b0;
    else
      frame_done <= sample && last_bit && frame_ok;   // Bad frames vanish here
  end

  always_ff @(posedge clk)
  begin
    if (sample && last_bit && frame_ok)
      frame_byte <= frame_next[8:1];
  end

  // ----------------------------------------
  // Assertions
  // ----------------------------------------
  // A frame takes eleven clock periods, so strobes never touch
  a_done_single: assert property (@(posedge clk) disable iff (reset)
    frame_done |=> !frame_done);

  a_state_known: assert property (@(posedge clk) disable iff (reset)
    !$isunknown(state));

endmodule

//--- design/ps2_xtcodes.sv
`timescale 1ns/1ps

module ps2_xtcodes (
  input  ps2_pkg::at_code_t at_code,   // Set 2 make code, bit 7 dropped
  output ps2_pkg::xt_code_t xt_code    // Set 1 make code
);

  // ----------------------------------------
  // Set 2 to set 1 table
  // ----------------------------------------
  always_comb
  begin
    case (at_code)
      // Function keys
      7'h01: xt_code = 7'h43;          // F9
      7'h03: xt_code = 7'h3F;          // F5
      7'h04: xt_code = 7'h3D;          // F3
      7'h05: xt_code = 7'h3B;          // F1
      7'h06: xt_code = 7'h3C;          // F2
      7'h07: xt_code = 7'h58;          // F12
      7'h09: xt_code = 7'h44;          // F10
      7'h0A: xt_code = 7'h42;          // F8
      7'h0B: xt_code = 7'h40;          // F6
      7'h0C: xt_code = 7'h3E;          // F4
      7'h78: xt_code = 7'h57;          // F11

      // Left block, modifiers
      7'h0D: xt_code = 7'h0F;          // Tab
      7'h0E: xt_code = 7'h29;          // Back quote
      7'h11: xt_code = 7'h38;          // Left alt
      7'h12: xt_code = 7'h2A;          // Left shift
      7'h14: xt_code = 7'h1D;          // Left ctrl
      7'h58: xt_code = 7'h3A;          // Caps lock
      7'h59: xt_code = 7'h36;          // Right shift

      // Letters, digits and punctuation
      7'h15: xt_code = 7'h10;          // Q
      7'h16: xt_code = 7'h02;          // 1
      7'h1A: xt_code = 7'h2C;          // Z
      7'h1B: xt_code = 7'h1F;          // S
      7'h1C: xt_code = 7'h1E;          // A
      7'h1D: xt_code = 7'h11;          // W
      7'h1E: xt_code = 7'h03;          // 2
      7'h21: xt_code = 7'h2E;          // C
      7'h22: xt_code = 7'h2D;          // X
      7'h23: xt_code = 7'h20;          // D
      7'h24: xt_code = 7'h12;          // E
      7'h25: xt_code = 7'h05;          // 4
      7'h26: xt_code = 7'h04;          // 3
      7'h29: xt_code = 7'h39;          // Space
      7'h2A: xt_code = 7'h2F;          // V
      7'h2B: xt_code = 7'h21;          // F
      7'h2C: xt_code = 7'h14;          // T
      7'h2D: xt_code = 7'h13;          // R
      7'h2E: xt_code = 7'h06;          // 5
      7'h31: xt_code = 7'h31;          // N
      7'h32: xt_code = 7'h30;          // B
      7'h33: xt_code = 7'h23;          // H
      7'h34: xt_code = 7'h22;          // G
      7'h35: xt_code = 7'h15;          // Y
      7'h36: xt_code = 7'h07;          // 6
      7'h3A: xt_code = 7'h32;          // M
      7'h3B: xt_code = 7'h24;          // J
      7'h3C: xt_code = 7'h16;          // U
      7'h3D: xt_code = 7'h08;          // 7
      7'h3E: xt_code = 7'h09;          // 8
      7'h41: xt_code = 7'h33;          // Comma
      7'h42: xt_code = 7'h25;          // K
      7'h43: xt_code = 7'h17;          // I
      7'h44: xt_code = 7'h18;          // O
      7'h45: xt_code = 7'h0B;          // 0
      7'h46: xt_code = 7'h0A;          // 9
      7'h49: xt_code = 7'h34;          // Period
      7'h4A: xt_code = 7'h35;          // Slash
      7'h4B: xt_code = 7'h26;          // L
      7'h4C: xt_code = 7'h27;          // Semicolon
      7'h4D: xt_code = 7'h19;          // P
      7'h4E: xt_code = 7'h0C;          // Minus
      7'h52: xt_code = 7'h28;          // Quote
      7'h54: xt_code = 7'h1A;          // Open bracket
      7'h55: xt_code = 7'h0D;          // Equals
      7'h5A: xt_code = 7'h1C;          // Enter
      7'h5B: xt_code = 7'h1B;          // Close bracket
      7'h5D: xt_code = 7'h2B;          // Backslash
      7'h61: xt_code = 7'h56;          // Extra key on 102-key boards
      7'h66: xt_code = 7'h0E;          // Backspace
      7'h76: xt_code = 7'h01;          // Esc

      // Keypad and locks
      7'h69: xt_code = 7'h4F;          // KP 1
      7'h6B: xt_code = 7'h4B;          // KP 4
      7'h6C: xt_code = 7'h47;          // KP 7
      7'h70: xt_code = 7'h52;          // KP 0
      7'h71: xt_code = 7'h53;          // KP point
      7'h72: xt_code = 7'h50;          // KP 2
      7'h73: xt_code = 7'h4C;          // KP 5
      7'h74: xt_code = 7'h4D;          // KP 6
      7'h75: xt_code = 7'h48;          // KP 8
      7'h77: xt_code = 7'h45;          // Num lock
      7'h79: xt_code = 7'h4E;          // KP plus
      7'h7A: xt_code = 7'h51;          // KP 3
      7'h7B: xt_code = 7'h4A;          // KP minus
      7'h7C: xt_code = 7'h37;          // KP star
      7'h7D: xt_code = 7'h49;          // KP 9
      7'h7E: xt_code = 7'h46;          // Scroll lock

      // No set 1 equivalent
      default: xt_code = 7'h00;
    endcase
  end

endmodule

//--- design/ps2_pkg.sv
package ps2_pkg;

  // ----------------------------------------
  // Link state machine
  // ----------------------------------------

  // Two level states and two one-cycle edge markers
  typedef enum logic [1:0] {
    clk_high  = 2'd0,               // Line idle or between bits
    fall_mark = 2'd1,               // Falling edge seen, sample data here
    clk_low   = 2'd2,               // Keyboard holds clock low
    rise_mark = 2'd3                // Rising edge seen
  } link_state_t;

  // ----------------------------------------
  // Code types
  // ----------------------------------------

  // Raw byte from the wire, also the byte handed to the host
  typedef logic [7:0] scan_byte_t;

  // Set 2 make code without its top bit
  typedef logic [6:0] at_code_t;

  // Set 1 (XT) make code, bit 7 of the output carries break
  typedef logic [6:0] xt_code_t;

endpackage

//--- design/ps2_cfg.svh
`ifndef PS2_CFG_SVH
`define PS2_CFG_SVH

// ----------------------------------------
// Link timing
// ----------------------------------------

// Clocks in 60 us at 50 MHz, idle time that ends a broken frame
`define PS2_TIMER_60USEC 3000
`define PS2_TIMER_BITS   12         // Wide enough for the 60 us count

// ----------------------------------------
// Code path options
// ----------------------------------------

`define PS2_TRAP_SHIFT   1          // Drop both shift keys by default
`define PS2_BUF_DEPTH    4          // Entries waiting for the host

// Special set 2 codes
`define PS2_RELEASE_CODE 8'hF0      // Break prefix
`define PS2_LEFT_SHIFT   8'h12
`define PS2_RIGHT_SHIFT  8'h59

`endif
